//--- verilog/periph_pkg.sv
package periph_pkg;

	// bus widths
	localparam int ADR_W = 6, DAT_W = 32;

	localparam int PWM_W  = 10;
	localparam int WDG_W  = 26;  // watchdog count, written from bits 26:1
	localparam int FAN_W  = 27;
	localparam int SEC_W  = 6;   // timer seconds
	localparam int GPIO_W = 16;

	localparam int SHIFT_HALF  = 4;  // clocks per SHCP half period
	localparam int SHIFT_DIV_W = (SHIFT_HALF > 1) ? $clog2(SHIFT_HALF) : 1;
	localparam logic [SHIFT_DIV_W-1:0] SHIFT_DIV_LAST = SHIFT_DIV_W'(SHIFT_HALF - 1);

	localparam int SEC_TICK_CYCLES = 50_000_000;
	localparam logic [GPIO_W-1:0] GPIO_RESET = 16'h8800;

	//--------------------------------------------------------------------------
	// register map, byte offsets
	//--------------------------------------------------------------------------
	typedef enum logic [ADR_W-1:0] {
		PWMC = 6'h00,
		WDG  = 6'h04,
		SFT  = 6'h08,
		SFTB = 6'h0c,
		FAN0 = 6'h10,
		FAN1 = 6'h14,
		TIME = 6'h18,
		GPIO = 6'h1c
	} reg_addr_e;

	typedef enum logic [1:0] {
		SFT_CLEAR = 2'd0,  // pulse MR_N
		SFT_SHIFT = 2'd1,  // shift 8 bits out
		SFT_LATCH = 2'd2,  // pulse STCP
		SFT_OE    = 2'd3   // load OE_N
	} sft_cmd_e;

	typedef struct packed {
		logic             stb;
		logic             we;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		sft_cmd_e   cmd;
		logic       oen;
		logic [7:0] data;
	} sft_req_t;

	typedef struct packed {
		logic shcp;
		logic ds;
		logic stcp;
		logic mr_n;
		logic oe_n;
	} hc595_pins_t;

	typedef struct packed {
		logic             wr;
		logic [DAT_W-1:0] dat;
	} tim_ctrl_t;

	typedef struct packed {
		logic             done1;
		logic             mask1;
		logic [SEC_W-1:0] cnt1;
		logic             done0;
		logic             mask0;
		logic [SEC_W-1:0] cnt0;
	} tim_stat_t;

endpackage

//--- verilog/periph_regs.sv
`timescale 1ns/1ps

module periph_regs import periph_pkg::*; (
	input  logic              CLK_I,
	input  logic              RST_I,

	input  wb_req_t           req,
	output logic              ack,
	output logic [DAT_W-1:0]  dat_o,

	// shift engines
	output logic              sft_start_a,
	output logic              sft_start_b,
	output sft_req_t          sft_req,
	input  logic              sft_done_a,
	input  logic              sft_done_b,
	input  logic              sft_oen_a,
	input  logic              sft_oen_b,

	input  logic [FAN_W-1:0]  fan0,
	input  logic [FAN_W-1:0]  fan1,

	output tim_ctrl_t         tim_ctrl,
	input  tim_stat_t         tim_stat,

	output logic              pwm,
	output logic              watch_dog,
	output logic [GPIO_W-1:0] gpio_out,
	input  logic [GPIO_W-1:0] gpio_in
);

	logic acc;
	logic wr;
	logic pwm_wr;
	logic wdg_wr;
	logic sft_wr;
	logic sftb_wr;
	logic time_wr;
	logic gpio_wr;
	reg_addr_e rd_sel;

	logic [PWM_W-1:0] pwm_duty;
	logic [PWM_W-1:0] pwm_cnt;
	logic wdg_en;
	logic [WDG_W-1:0] wdg_cnt;
	logic [1:0] sft_done_r;     // {b, a}
	logic [GPIO_W-1:0] gpio_in_r;

	//--------------------------------------------------------------------------
	// bus ack and decode
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			ack <= 1'b0;
		else
			ack <= req.stb && !ack;
	end

	assign acc = req.stb && !ack;  // one decode cycle per access
	assign wr  = acc && req.we;

	assign pwm_wr  = wr && (req.adr == PWMC);
	assign wdg_wr  = wr && (req.adr == WDG);
	assign sft_wr  = wr && (req.adr == SFT);
	assign sftb_wr = wr && (req.adr == SFTB);
	assign time_wr = wr && (req.adr == TIME);
	assign gpio_wr = wr && (req.adr == GPIO);

	// PWM
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			pwm_duty <= '0;
			pwm_cnt  <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;  // free running
			if (pwm_wr)
				pwm_duty <= req.dat[PWM_W-1:0];
		end
	end

	assign pwm = (pwm_cnt <= pwm_duty);

	//--------------------------------------------------------------------------
	// watchdog
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wdg_en  <= 1'b0;
			wdg_cnt <= '0;
		end else begin
			if (wdg_wr)
				wdg_en <= req.dat[0];
			// reload only when enabled or being enabled
			if (wdg_wr && (wdg_en || req.dat[0]))
				wdg_cnt <= req.dat[WDG_W:1];
			else if (wdg_cnt != '0)
				wdg_cnt <= wdg_cnt - 1'b1;
		end
	end

	assign watch_dog = wdg_en && (wdg_cnt == WDG_W'(2) || wdg_cnt == WDG_W'(1));

	// one request word for both engines
	assign sft_start_a = sft_wr;
	assign sft_start_b = sftb_wr;
	assign sft_req = '{cmd: sft_cmd_e'(req.dat[1:0]), oen: req.dat[2], data: req.dat[15:8]};

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			sft_done_r <= 2'b00;
		else  // write clears, done pulse sets
			sft_done_r <= (sft_done_r | {sft_done_b, sft_done_a}) & ~{sftb_wr, sft_wr};
	end

	assign tim_ctrl = '{wr: time_wr, dat: req.dat};

	// GPIO
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			gpio_out <= GPIO_RESET;
		else if (gpio_wr)
			gpio_out <= req.dat[GPIO_W-1:0];
	end

	always_ff @(posedge CLK_I)
		gpio_in_r <= gpio_in;

	//--------------------------------------------------------------------------
	// read back
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			rd_sel <= PWMC;
		else if (acc && !req.we)
			rd_sel <= reg_addr_e'(req.adr);
	end

	always_comb begin
		case (rd_sel)
			PWMC:    dat_o = {{(DAT_W-PWM_W){1'b0}}, pwm_duty};
			WDG:     dat_o = {5'b0, wdg_cnt, wdg_en};
			SFT:     dat_o = {28'b0, sft_done_r[0], sft_oen_a, 2'b0};
			SFTB:    dat_o = {28'b0, sft_done_r[1], sft_oen_b, 2'b0};
			FAN0:    dat_o = {{(DAT_W-FAN_W){1'b0}}, fan0};
			FAN1:    dat_o = {{(DAT_W-FAN_W){1'b0}}, fan1};
			TIME:    dat_o = {7'b0, tim_stat.done1, tim_stat.cnt1, tim_stat.mask1, 1'b0,
			                  7'b0, tim_stat.done0, tim_stat.cnt0, tim_stat.mask0, 1'b0};
			GPIO:    dat_o = {gpio_in_r, gpio_out};
			default: dat_o = '0;
		endcase
	end

	// each start is answered by a single-cycle done pulse
	done_pulse_a: assert property (@(posedge CLK_I) disable iff (RST_I)
		sft_done_a |=> !sft_done_a);

	done_pulse_b: assert property (@(posedge CLK_I) disable iff (RST_I)
		sft_done_b |=> !sft_done_b);

endmodule

//--- verilog/hc595_shift.sv
`timescale 1ns/1ps

module hc595_shift import periph_pkg::*; (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        start,
	input  sft_req_t    req,
	output logic        done,
	output hc595_pins_t pins
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_SHIFT,
		ST_LATCH
	} state_e;

	state_e state;
	logic [SHIFT_DIV_W-1:0] div;
	logic [3:0] half;          // half periods done in this command
	logic [3:0] last_half;
	logic [7:0] sreg;          // MSB drives DS
	logic shcp;
	logic stcp;
	logic mr_n;
	logic oe_n;

	assign last_half = (state == ST_SHIFT) ? 4'd15 : 4'd1;

	//--------------------------------------------------------------------------
	// sequencer
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state <= ST_IDLE;
			div   <= '0;
			half  <= '0;
			sreg  <= '0;
			shcp  <= 1'b0;
			stcp  <= 1'b0;
			mr_n  <= 1'b1;
			oe_n  <= 1'b1;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state == ST_IDLE) begin
				if (start) begin
					div  <= '0;
					half <= '0;
					unique case (req.cmd)
						SFT_CLEAR: begin
							state <= ST_CLEAR;
							mr_n  <= 1'b0;
						end
						SFT_SHIFT: begin
							state <= ST_SHIFT;
							sreg  <= req.data;
						end
						SFT_LATCH: begin
							state <= ST_LATCH;
							stcp  <= 1'b1;
						end
						SFT_OE: begin
							// latch timing, STCP stays low
							state <= ST_LATCH;
							oe_n  <= req.oen;
						end
					endcase
				end
			end else if (div != SHIFT_DIV_LAST) begin
				div <= div + 1'b1;
			end else begin
				// end of a half period
				div  <= '0;
				half <= half + 1'b1;
				mr_n <= 1'b1;
				stcp <= 1'b0;
				if (state == ST_SHIFT) begin
					shcp <= ~half[0];  // rises after the low half
					if (half[0])
						sreg <= {sreg[6:0], 1'b0};
				end
				if (half == last_half) begin
					state <= ST_IDLE;
					done  <= 1'b1;
				end
			end
		end
	end

	assign pins = '{shcp: shcp, ds: sreg[7], stcp: stcp, mr_n: mr_n, oe_n: oe_n};

	// register block must wait for done before the next command
	no_start_busy: assert property (@(posedge CLK_I) disable iff (RST_I)
		start |-> state == ST_IDLE);

	no_stcp_shcp: assert property (@(posedge CLK_I) disable iff (RST_I)
		!(pins.stcp && pins.shcp));

endmodule

//--- verilog/fan_tach.sv
`timescale 1ns/1ps

module fan_tach import periph_pkg::*; (
	input  logic             CLK_I,
	input  logic             RST_I,
	input  logic             tick,
	input  logic [1:0]       fan_in,
	output logic [FAN_W-1:0] fan0,
	output logic [FAN_W-1:0] fan1
);

	logic [2:0]       sync [2];   // bit 0 is the first stage
	logic [FAN_W-1:0] cnt  [2];
	logic [FAN_W-1:0] held [2];
	logic [1:0]       fall;

	//--------------------------------------------------------------------------
	// input synchronizers
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			sync[0] <= '0;
			sync[1] <= '0;
		end else begin
			sync[0] <= {sync[0][1:0], fan_in[0]};
			sync[1] <= {sync[1][1:0], fan_in[1]};
		end
	end

	assign fall[0] = sync[0][2] && !sync[0][1];
	assign fall[1] = sync[1][2] && !sync[1][1];

	// edge counters latched and restarted every tick
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			for (int i = 0; i < 2; i++) begin
				cnt[i]  <= '0;
				held[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (tick) begin
					held[i] <= cnt[i];
					cnt[i]  <= {{(FAN_W-1){1'b0}}, fall[i]};  // keep an edge on the tick
				end else if (fall[i]) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign fan0 = held[0];
	assign fan1 = held[1];

endmodule

//--- verilog/sec_timer.sv
`timescale 1ns/1ps

module sec_timer import periph_pkg::*; #(
	parameter int TICK_PERIOD = SEC_TICK_CYCLES
) (
	input  logic      CLK_I,
	input  logic      RST_I,
	input  tim_ctrl_t ctrl,
	output logic      tick,
	output tim_stat_t stat,
	output logic      int0,
	output logic      int1
);

	logic [31:0]      tick_cnt;
	logic [SEC_W-1:0] cnt  [2];
	logic [1:0]       done;
	logic [1:0]       mask;
	logic [1:0]       load;

	//--------------------------------------------------------------------------
	// one second tick
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign tick = (tick_cnt == 32'(TICK_PERIOD));

	// timer 0 owns bits 15:0, timer 1 bits 31:16
	assign load = {ctrl.wr && ctrl.dat[16], ctrl.wr && ctrl.dat[0]};

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			for (int i = 0; i < 2; i++)
				cnt[i] <= '0;
			done <= 2'b00;
			mask <= 2'b11;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (ctrl.wr)
					mask[i] <= ctrl.dat[16*i+1];
				if (load[i])
					cnt[i] <= ctrl.dat[16*i+2 +: SEC_W];
				else if (tick && cnt[i] != '0)
					cnt[i] <= cnt[i] - 1'b1;
				// expiry wins over a clear in the same cycle
				if (tick && cnt[i] == SEC_W'(1) && !load[i])
					done[i] <= 1'b1;
				else if (ctrl.wr && ctrl.dat[16*i+8])
					done[i] <= 1'b0;
			end
		end
	end

	assign int0 = done[0] && !mask[0];
	assign int1 = done[1] && !mask[1];

	assign stat = '{done1: done[1], mask1: mask[1], cnt1: cnt[1],
	                done0: done[0], mask0: mask[0], cnt0: cnt[0]};

	// interrupt only rises with done, right after an expiry tick or an unmask write
	int0_src: assert property (@(posedge CLK_I) disable iff (RST_I)
		$rose(int0) |-> stat.done0 && ($past(tick) || $past(ctrl.wr)));

	int1_src: assert property (@(posedge CLK_I) disable iff (RST_I)
		$rose(int1) |-> stat.done1 && ($past(tick) || $past(ctrl.wr)));

endmodule

//--- verilog/periph_top.sv
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
	parameter int TICK_PERIOD = SEC_TICK_CYCLES
) (
	input  logic              CLK_I,
	input  logic              RST_I,

	// wishbone slave
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [ADR_W-1:0]  wb_adr,
	input  logic [DAT_W-1:0]  wb_dat_i,
	output logic              wb_ack,
	output logic [DAT_W-1:0]  wb_dat_o,

	output logic              pwm,
	output logic              watch_dog,
	output hc595_pins_t       sft_a,
	output hc595_pins_t       sft_b,
	input  logic [1:0]        fan_in,
	output logic              time0_int,
	output logic              time1_int,
	output logic [GPIO_W-1:0] gpio_out,
	input  logic [GPIO_W-1:0] gpio_in
);

	wb_req_t          req;
	sft_req_t         sft_req;
	logic             sft_start_a;
	logic             sft_start_b;
	logic             sft_done_a;
	logic             sft_done_b;
	tim_ctrl_t        tim_ctrl;
	tim_stat_t        tim_stat;
	logic             tick;
	logic [FAN_W-1:0] fan0;
	logic [FAN_W-1:0] fan1;

	assign req = '{stb: wb_stb, we: wb_we, adr: wb_adr, dat: wb_dat_i};

	periph_regs i_regs (
		.CLK_I, .RST_I, .req,
		.ack (wb_ack), .dat_o (wb_dat_o),
		.sft_start_a, .sft_start_b, .sft_req,
		.sft_done_a, .sft_done_b,
		.sft_oen_a (sft_a.oe_n), .sft_oen_b (sft_b.oe_n),
		.fan0, .fan1, .tim_ctrl, .tim_stat,
		.pwm, .watch_dog, .gpio_out, .gpio_in
	);

	hc595_shift i_sft_a (.CLK_I, .RST_I, .start (sft_start_a), .req (sft_req),
		.done (sft_done_a), .pins (sft_a));

	hc595_shift i_sft_b (.CLK_I, .RST_I, .start (sft_start_b), .req (sft_req),
		.done (sft_done_b), .pins (sft_b));

	fan_tach i_tach (.CLK_I, .RST_I, .tick, .fan_in, .fan0, .fan1);

	sec_timer #(.TICK_PERIOD (TICK_PERIOD)) i_timer (
		.CLK_I, .RST_I, .ctrl (tim_ctrl), .tick, .stat (tim_stat),
		.int0 (time0_int), .int1 (time1_int)
	);

endmodule

//--- sim/periph_tb.sv
`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

	localparam int TICK        = 199;
	localparam int TICK_CYCLES = TICK + 1;
	localparam int CLK_PERIOD  = 40;
	localparam int RUN_CYCLES  = 1100 + 500 + 12 * TICK_CYCLES + 400;  // all tests plus margin

	logic              clk;
	logic              rst;
	logic              stb;
	logic              we;
	logic [ADR_W-1:0]  adr;
	logic [DAT_W-1:0]  dat_i;
	logic              ack;
	logic [DAT_W-1:0]  dat_o;
	logic              pwm;
	logic              watch_dog;
	hc595_pins_t       sft_a;
	hc595_pins_t       sft_b;
	logic [1:0]        fan_in;
	logic              time0_int;
	logic              time1_int;
	logic [GPIO_W-1:0] gpio_out;
	logic [GPIO_W-1:0] gpio_in;

	int          errors = 0;
	int          checks = 0;
	int          test_base = 0;
	logic [31:0] lfsr = 32'h601b_19b2;

	periph_top #(.TICK_PERIOD (TICK)) i_dut (
		.CLK_I (clk), .RST_I (rst),
		.wb_stb (stb), .wb_we (we), .wb_adr (adr), .wb_dat_i (dat_i),
		.wb_ack (ack), .wb_dat_o (dat_o),
		.pwm, .watch_dog, .sft_a, .sft_b, .fan_in,
		.time0_int, .time1_int, .gpio_out, .gpio_in
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic note_failure(input string what);
		errors++;
		$display("Error: %s at %0t", what, $time);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%-10s done, %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	//------------------------------------------------------------------------
	// bus access ending on the edge that drops STB
	//------------------------------------------------------------------------
	task automatic bus_access(input logic write, input logic [ADR_W-1:0] a,
		input logic [DAT_W-1:0] d, output logic [DAT_W-1:0] q);
		int n;
		n = 0;
		@(posedge clk);
		stb   <= 1'b1;
		we    <= write;
		adr   <= a;
		dat_i <= d;
		@(negedge clk);
		while (!ack && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!ack)
			note_failure("bus access got no ACK");
		q = dat_o;  // valid in the ACK cycle
		@(posedge clk);
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [ADR_W-1:0] a, input logic [DAT_W-1:0] d);
		logic [DAT_W-1:0] unused;
		bus_access(1'b1, a, d, unused);
	endtask

	task automatic wb_read(input logic [ADR_W-1:0] a, output logic [DAT_W-1:0] q);
		bus_access(1'b0, a, '0, q);
	endtask

	// counts edges on one 74HC595 chain starting from its idle levels
	task automatic watch_shift(input int e, input int cycles, output logic [7:0] bits,
		output int shcp_up, output int stcp_up, output int mr_down);
		hc595_pins_t p;
		hc595_pins_t prev;
		prev = '{shcp: 1'b0, ds: 1'b0, stcp: 1'b0, mr_n: 1'b1, oe_n: 1'b1};
		bits = '0;
		shcp_up = 0;
		stcp_up = 0;
		mr_down = 0;
		repeat (cycles) begin
			@(negedge clk);
			p = e ? sft_b : sft_a;
			if (p.shcp && !prev.shcp) begin
				bits = {bits[6:0], p.ds};
				shcp_up++;
			end
			if (p.stcp && !prev.stcp)
				stcp_up++;
			if (!p.mr_n && prev.mr_n)
				mr_down++;
			prev = p;
		end
	endtask

	task automatic wait_tick();
		int n;
		n = 0;
		@(negedge clk);
		while (!i_dut.tick && n < 2 * TICK_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!i_dut.tick)
			note_failure("second tick never came");
	endtask

	// index 1 is the first cycle after the write access
	task automatic watch_wdg(input int cycles, output int first, output int high);
		first = -1;
		high = 0;
		for (int i = 1; i <= cycles; i++) begin
			@(negedge clk);
			if (watch_dog) begin
				high++;
				if (first < 0)
					first = i;
			end
		end
	endtask

	//------------------------------------------------------------------------
	// bus protocol
	//------------------------------------------------------------------------
	ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
		(stb && !ack) |=> ack) else note_failure("ACK did not follow STB");

	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		ack |=> !ack) else note_failure("ACK held for two cycles");

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Error: run did not finish in time");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic [31:0] q;
		logic [31:0] w;
		logic [15:0] gi;
		logic [7:0]  bits;
		int a, b, c, n, s0, n0, n1, k;
		logic [ADR_W-1:0] sa;

		clk = 1'b0;
		rst = 1'b1;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_i = '0;
		fan_in = 2'b00;
		gpio_in = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// reset values and GPIO
		@(negedge clk);
		check("ack", ack, 0);
		check("watch_dog", watch_dog, 0);
		check("time_int", {time1_int, time0_int}, 0);
		check("sft_a", sft_a, 5'b00011);
		check("sft_b", sft_b, 5'b00011);
		check("gpio_out", gpio_out, 32'(GPIO_RESET));
		wb_read(TIME, q);
		check("time", q, 32'h0002_0002);  // both masks set
		gi = rand_bits(16);
		gpio_in <= gi;
		w = rand_bits(32);
		wb_write(GPIO, w);
		check("gpio_out", gpio_out, w[15:0]);
		wb_read(GPIO, q);
		check("gpio", q, {gi, w[15:0]});
		finish_test("reset/bus");

		// PWM
		w = rand_bits(10);
		wb_write(PWMC, w);
		n = 0;
		repeat (1024) begin
			@(negedge clk);
			n += pwm;
		end
		check("pwm_high", n, w + 1);
		finish_test("pwm");

		// both shift engines
		for (int e = 0; e < 2; e++) begin
			sa = e ? SFTB : SFT;
			w = rand_bits(8);
			wb_write(sa, {16'b0, w[7:0], 6'b0, SFT_SHIFT});
			watch_shift(e, 16 * SHIFT_HALF + 4, bits, a, b, c);
			check("ds_byte", bits, w[7:0]);
			check("shcp_rises", a, 8);
			check("stcp_rises", b, 0);
			wb_read(sa, q);
			check("sft_done", q[3], 1);
			wb_write(sa, {30'b0, SFT_LATCH});
			watch_shift(e, 2 * SHIFT_HALF + 4, bits, a, b, c);
			check("stcp_rises", b, 1);
			check("shcp_rises", a, 0);
			wb_read(sa, q);
			check("sft_done", q[3], 1);
			wb_write(sa, {30'b0, SFT_CLEAR});
			watch_shift(e, 2 * SHIFT_HALF + 4, bits, a, b, c);
			check("mr_n_falls", c, 1);
			wb_read(sa, q);
			check("sft_done", q[3], 1);
			for (int v = 0; v < 2; v++) begin
				wb_write(sa, {29'b0, v[0], SFT_OE});
				wb_read(sa, q);  // engine still busy
				check("sft_done", q[3], 0);
				check("sft_oen", q[2], v);
				check("oe_n", e ? sft_b.oe_n : sft_a.oe_n, v);
				repeat (2 * SHIFT_HALF + 4) @(posedge clk);
				wb_read(sa, q);
				check("sft_done", q[3], 1);
			end
		end
		finish_test("shift");

		// tachometer with more edges on fan 1 than on fan 0
		n0 = 3 + rand_bits(3);
		n1 = n0 + 1 + rand_bits(2);
		wait_tick();
		for (int i = 0; i < n1; i++) begin
			@(posedge clk);
			fan_in <= {1'b1, i < n0};
			repeat (2) @(posedge clk);
			fan_in <= 2'b00;
			@(posedge clk);
		end
		wait_tick();
		wb_read(FAN0, q);
		check("fan0", q, n0);
		wb_read(FAN1, q);
		check("fan1", q, n1);
		finish_test("fan");

		// timer 0 unmasked and timer 1 masked with one second
		s0 = 2 + rand_bits(2);
		wb_write(TIME, 32'h0007_0001 | (s0 << 2));
		n = 0;
		k = 0;
		while (!time0_int && n < s0 * TICK_CYCLES + 4) begin
			@(negedge clk);
			n++;
			k |= time1_int;
		end
		if (!time0_int || n < (s0 - 1) * TICK_CYCLES - 2)
			note_failure("timer 0 interrupt outside its window");
		check("time1_int", k, 0);
		wb_read(TIME, q);
		check("time", q, 32'h0102_0100);
		wb_write(TIME, 32'h0102_0102);  // clear both done and mask both
		wb_read(TIME, q);
		check("time", q, 32'h0002_0002);
		check("time0_int", time0_int, 0);
		finish_test("timer");

		// watchdog pulse, reload and disable
		k = 5 + rand_bits(5);
		wb_write(WDG, (k << 1) | 1);
		watch_wdg(k + 6, a, b);
		check("wdg_start", a, k - 2);
		check("wdg_high", b, 2);
		wb_write(WDG, (30 << 1) | 1);
		repeat (10) @(posedge clk);
		wb_write(WDG, (30 << 1) | 1);
		watch_wdg(36, a, b);
		check("wdg_start", a, 28);
		check("wdg_high", b, 2);
		wb_write(WDG, (20 << 1) | 1);
		repeat (5) @(posedge clk);
		wb_write(WDG, 20 << 1);  // count keeps running with the enable cleared
		watch_wdg(40, a, b);
		check("wdg_high", b, 0);
		finish_test("watchdog");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- periph_top.f
verilog/periph_pkg.sv
verilog/periph_regs.sv
verilog/hc595_shift.sv
verilog/fan_tach.sv
verilog/sec_timer.sv
verilog/periph_top.sv
sim/periph_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= periph_top.f
TB_TOP    ?= periph_tb
RTL_TOP   ?= periph_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wall

RTL_SRCS := $(filter verilog/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then exit 1; fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
